/* filelist.f */
logic/dcachePkg.sv
logic/arrayIf.sv
logic/refillIf.sv
logic/dcacheCtrl.sv
logic/dcacheArrays.sv
logic/busPort.sv
logic/dcacheTop.sv
sim/tbClock.sv
sim/dcache_props.sv
sim/dcacheTb.sv

/* run.sh */
#!/usr/bin/env bash
# build and run the data cache testbench with Verilator
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert --timescale 1ns/1ps \
  -f filelist.f --top-module dcacheTb -o dcacheSim
if [ $? -ne 0 ]; then
  echo "Verilator build failed"
  exit 1
fi

simOut="$(./obj_dir/dcacheSim 2>&1)"
simStatus=$?
echo "$simOut"
if [ $simStatus -ne 0 ]; then
  echo "simulation exited with status $simStatus"
  exit 1
fi

if grep -qx "TEST RESULT: PASS" <<< "$simOut"; then
  exit 0
fi
exit 1

/* sim/dcacheTb.sv */
`timescale 1ns/1ps
`default_nettype none

module dcacheTb
  import dcachePkg::*;
();

  localparam int WAIT_LIMIT = 200;

  logic clk;
  logic rst_n;
  logic reqValid_i;
  logic reqWrite_i;
  logic [ADDR_W-1:0] reqAddr_i;
  word_t reqData_i;
  logic [MASK_W-1:0] reqMask_i;
  logic reqReady_o;
  logic respValid_o;
  word_t respData_o;
  logic rdReqValid_o;
  logic rdReqReady_i;
  logic [ADDR_W-1:0] rdReqAddr_o;
  logic rdBeatValid_i;
  word_t rdBeatData_i;
  logic rdBeatLast_i;
  logic wrReqValid_o;
  logic wrReqReady_i;
  logic [ADDR_W-1:0] wrReqAddr_o;
  line_t wrLineData_o;

  // backing memory and the words that stores have changed
  word_t memModel [logic [ADDR_W-1:0]];
  word_t expMap [logic [ADDR_W-1:0]];
  // lines stored to since their last write-back
  bit dirtyLines [logic [ADDR_W-1:0]];

  int checkCount = 0;
  int errorCount = 0;
  int readCount = 0;
  int writeCount = 0;
  logic [ADDR_W-1:0] lastReadAddr;
  logic aborted = 1'b0;
  string curTest = "init";

  tbClock uClock (
    .clk_o   (clk),
    .rst_n_o (rst_n)
  );

  dcacheTop dut_i (
    .clk           (clk),
    .rst_n         (rst_n),
    .reqValid_i    (reqValid_i),
    .reqWrite_i    (reqWrite_i),
    .reqAddr_i     (reqAddr_i),
    .reqData_i     (reqData_i),
    .reqMask_i     (reqMask_i),
    .reqReady_o    (reqReady_o),
    .respValid_o   (respValid_o),
    .respData_o    (respData_o),
    .rdReqValid_o  (rdReqValid_o),
    .rdReqReady_i  (rdReqReady_i),
    .rdReqAddr_o   (rdReqAddr_o),
    .rdBeatValid_i (rdBeatValid_i),
    .rdBeatData_i  (rdBeatData_i),
    .rdBeatLast_i  (rdBeatLast_i),
    .wrReqValid_o  (wrReqValid_o),
    .wrReqReady_i  (wrReqReady_i),
    .wrReqAddr_o   (wrReqAddr_o),
    .wrLineData_o  (wrLineData_o)
  );

  bind dcacheTop dcacheProps uProps (
    .clk_i        (clk),
    .rst_n_i      (rst_n),
    .reqReady_i   (reqReady_o),
    .respValid_i  (respValid_o),
    .rdReqValid_i (rdReqValid_o),
    .wrReqValid_i (wrReqValid_o),
    .wrReqReady_i (wrReqReady_i)
  );

  task automatic checkEq(input string name, input word_t expected, input word_t actual);
    checkCount++;
    if (expected !== actual) begin
      errorCount++;
      $display("ERR %s: expected %h, actual %h", name, expected, actual);
    end
  endtask

  task automatic reportTimeout(input string what);
    errorCount++;
    aborted = 1'b1;
    $display("%s: timed out waiting for %s", curTest, what);
  endtask

  function automatic logic [ADDR_W-1:0] lineBase(input logic [ADDR_W-1:0] addr);
    return {addr[ADDR_W-1:OFFSET_W], {OFFSET_W{1'b0}}};
  endfunction

  // untouched words get a random value on first use
  function automatic word_t modelWord(input logic [ADDR_W-1:0] addr);
    if (!memModel.exists(addr)) begin
      memModel[addr] = {$urandom, $urandom};
    end
    return memModel[addr];
  endfunction

  function automatic word_t expectedWord(input logic [ADDR_W-1:0] addr);
    if (expMap.exists(addr)) begin
      return expMap[addr];
    end
    return modelWord(addr);
  endfunction

  function automatic word_t mergeBytes(input word_t oldWord, input word_t newWord,
                                       input logic [MASK_W-1:0] mask);
    word_t result;
    result = oldWord;
    for (int b = 0; b < MASK_W; b++) begin
      if (mask[b]) begin
        result[b*8 +: 8] = newWord[b*8 +: 8];
      end
    end
    return result;
  endfunction

  task automatic serveRead();
    int unsigned delay;
    logic [ADDR_W-1:0] base;
    delay = $urandom_range(3, 0);
    repeat (delay) begin
      @(posedge clk);
      #1;
    end
    base = rdReqAddr_o;
    readCount++;
    lastReadAddr = base;
    rdReqReady_i = 1'b1;
    @(posedge clk);
    #1;
    rdReqReady_i = 1'b0;
    // lowest word first, last flag on the fourth beat
    for (int b = 0; b < BEATS; b++) begin
      rdBeatValid_i = 1'b1;
      rdBeatData_i = modelWord(base + 32'(b * 8));
      rdBeatLast_i = (b == BEATS - 1);
      @(posedge clk);
      #1;
    end
    rdBeatValid_i = 1'b0;
    rdBeatLast_i = 1'b0;
  endtask

  task automatic serveWrite();
    int unsigned delay;
    logic [ADDR_W-1:0] base;
    line_t lineData;
    delay = $urandom_range(3, 0);
    repeat (delay) begin
      @(posedge clk);
      #1;
    end
    base = wrReqAddr_o;
    lineData = wrLineData_o;
    writeCount++;
    // only a line that took a store may leave the cache
    checkEq({curTest, " wb line dirty"}, 64'(1), 64'(dirtyLines.exists(base)));
    if (dirtyLines.exists(base)) begin
      dirtyLines.delete(base);
    end
    for (int w = 0; w < BEATS; w++) begin
      checkEq({curTest, " wb data"}, expectedWord(base + 32'(w * 8)),
              lineData[w*XLEN +: XLEN]);
      memModel[base + 32'(w * 8)] = lineData[w*XLEN +: XLEN];
    end
    wrReqReady_i = 1'b1;
    @(posedge clk);
    #1;
    wrReqReady_i = 1'b0;
  endtask

  // memory model, read side
  initial begin : readServer
    rdReqReady_i = 1'b0;
    rdBeatValid_i = 1'b0;
    rdBeatData_i = '0;
    rdBeatLast_i = 1'b0;
    forever begin
      @(posedge clk);
      #1;
      if (rdReqValid_o) begin
        serveRead();
      end
    end
  end

  // memory model, write-back side
  initial begin : writeServer
    wrReqReady_i = 1'b0;
    forever begin
      @(posedge clk);
      #1;
      if (wrReqValid_o) begin
        serveWrite();
      end
    end
  end

  // one request, returns the load data and cycles from acceptance to response
  task automatic doRequest(input logic isWrite, input logic [ADDR_W-1:0] addr,
                           input word_t data, input logic [MASK_W-1:0] mask,
                           output word_t rdata, output int latency);
    int n;
    rdata = '0;
    latency = 0;
    if (aborted) begin
      return;
    end
    n = 0;
    while (!reqReady_o && n < WAIT_LIMIT) begin
      @(posedge clk);
      #1;
      n++;
    end
    if (!reqReady_o) begin
      reportTimeout("reqReady_o");
      return;
    end
    if (isWrite) begin
      expMap[addr] = mergeBytes(expectedWord(addr), data, mask);
      dirtyLines[lineBase(addr)] = 1'b1;
    end
    reqValid_i = 1'b1;
    reqWrite_i = isWrite;
    reqAddr_i = addr;
    reqData_i = data;
    reqMask_i = mask;
    @(posedge clk);
    #1;
    reqValid_i = 1'b0;
    latency = 1;
    while (!respValid_o && latency < WAIT_LIMIT) begin
      @(posedge clk);
      #1;
      latency++;
    end
    if (!respValid_o) begin
      reportTimeout("respValid_o");
      return;
    end
    rdata = respData_o;
  endtask

  task automatic waitReset();
    int n;
    n = 0;
    @(posedge clk);
    #1;
    while (!rst_n && n < WAIT_LIMIT) begin
      @(posedge clk);
      #1;
      n++;
    end
    if (!rst_n) begin
      reportTimeout("rst_n release");
    end
  endtask

  task automatic resetStateTest();
    curTest = "resetState";
    checkEq(curTest, 64'(1), 64'(reqReady_o));
    checkEq(curTest, 64'(0), 64'(respValid_o));
    checkEq(curTest, 64'(0), 64'(rdReqValid_o));
    checkEq(curTest, 64'(0), 64'(wrReqValid_o));
  endtask

  task automatic loadMissHitTest();
    logic [ADDR_W-1:0] addrA;
    logic [ADDR_W-1:0] addrB;
    word_t expData;
    word_t rdata;
    int latency;
    int readsBefore;
    curTest = "loadMissHit";
    addrA = {21'h00005, 6'd3, 2'd1, 3'b000};
    addrB = {21'h00005, 6'd3, 2'd2, 3'b000};
    readsBefore = readCount;
    expData = expectedWord(addrA);
    doRequest(1'b0, addrA, '0, '0, rdata, latency);
    checkEq(curTest, expData, rdata);
    checkEq(curTest, 64'(readsBefore + 1), 64'(readCount));
    checkEq(curTest, 64'({addrA[ADDR_W-1:OFFSET_W], 5'b0}), 64'(lastReadAddr));
    // same line, now resident
    readsBefore = readCount;
    expData = expectedWord(addrB);
    doRequest(1'b0, addrB, '0, '0, rdata, latency);
    checkEq(curTest, expData, rdata);
    checkEq(curTest, 64'(1), 64'(latency));
    checkEq(curTest, 64'(readsBefore), 64'(readCount));
  endtask

  task automatic maskedStoreTest();
    logic [ADDR_W-1:0] addr;
    word_t oldData;
    word_t stData;
    word_t rdata;
    int latency;
    curTest = "maskedStore";
    addr = {21'h00005, 6'd3, 2'd1, 3'b000};
    oldData = expectedWord(addr);
    stData = {$urandom, $urandom};
    doRequest(1'b1, addr, stData, 8'h5a, rdata, latency);
    checkEq(curTest, 64'(1), 64'(latency));
    doRequest(1'b0, addr, '0, '0, rdata, latency);
    checkEq(curTest, mergeBytes(oldData, stData, 8'h5a), rdata);
  endtask

  task automatic dirtyEvictionTest();
    logic [ADDR_W-1:0] addr;
    word_t expData;
    word_t rdata;
    int latency;
    int writesBefore;
    curTest = "dirtyEviction";
    writesBefore = writeCount;
    // three tags on set 9, one more than the ways
    for (int t = 0; t < 3; t++) begin
      addr = {21'(64 + t), 6'd9, 2'd0, 3'b000};
      doRequest(1'b1, addr, {$urandom, $urandom}, 8'hff, rdata, latency);
      addr = {21'(64 + t), 6'd9, 2'd3, 3'b000};
      doRequest(1'b1, addr, {$urandom, $urandom}, 8'hf0, rdata, latency);
    end
    for (int t = 0; t < 3; t++) begin
      for (int w = 0; w < BEATS; w += 3) begin
        addr = {21'(64 + t), 6'd9, 2'(w), 3'b000};
        expData = expectedWord(addr);
        doRequest(1'b0, addr, '0, '0, rdata, latency);
        checkEq(curTest, expData, rdata);
      end
    end
    if (writeCount == writesBefore) begin
      errorCount++;
      $display("%s: no write-back was issued", curTest);
    end
  endtask

  task automatic randomTrafficTest();
    logic [ADDR_W-1:0] addr;
    tag_t tagV;
    index_t idxV;
    logic [1:0] wordV;
    logic isWrite;
    word_t expData;
    word_t rdata;
    int latency;
    curTest = "randomTraffic";
    for (int i = 0; i < 200; i++) begin
      tagV = 21'(256 + $urandom_range(3, 0));
      idxV = 6'(16 + $urandom_range(2, 0));
      wordV = 2'($urandom_range(3, 0));
      addr = {tagV, idxV, wordV, 3'b000};
      isWrite = 1'($urandom_range(1, 0));
      if (isWrite) begin
        doRequest(1'b1, addr, {$urandom, $urandom}, 8'($urandom), rdata, latency);
      end else begin
        expData = expectedWord(addr);
        doRequest(1'b0, addr, '0, '0, rdata, latency);
        checkEq(curTest, expData, rdata);
      end
    end
  endtask

  initial begin : mainFlow
    void'($urandom(32'h2f232923));
    reqValid_i = 1'b0;
    reqWrite_i = 1'b0;
    reqAddr_i = '0;
    reqData_i = '0;
    reqMask_i = '0;
    waitReset();
    resetStateTest();
    loadMissHitTest();
    maskedStoreTest();
    dirtyEvictionTest();
    randomTrafficTest();
    $display("checks: %0d, errors: %0d, reads: %0d, write-backs: %0d",
             checkCount, errorCount, readCount, writeCount);
    if (errorCount == 0) begin
      $display("TEST RESULT: PASS");
    end else begin
      $display("TEST RESULT: FAIL");
    end
    $finish;
  end

endmodule

`default_nettype wire

/* sim/dcache_props.sv */
`timescale 1ns/1ps
`default_nettype none

module dcacheProps (
  input logic clk_i,
  input logic rst_n_i,
  input logic reqReady_i,
  input logic respValid_i,
  input logic rdReqValid_i,
  input logic wrReqValid_i,
  input logic wrReqReady_i
);

  // one memory request at a time
  property noDualRequest;
    @(posedge clk_i) disable iff (!rst_n_i)
      !(rdReqValid_i && wrReqValid_i);
  endproperty

  property wrHeldUntilReady;
    @(posedge clk_i) disable iff (!rst_n_i)
      wrReqValid_i && !wrReqReady_i |=> wrReqValid_i;
  endproperty

  // responses only come while a request is in flight
  property noRespWhileReady;
    @(posedge clk_i) disable iff (!rst_n_i)
      !(reqReady_i && respValid_i);
  endproperty

  assert property (noDualRequest)
    else $error("read and write requests are high in the same cycle");
  assert property (wrHeldUntilReady)
    else $error("write request dropped before it was accepted");
  assert property (noRespWhileReady)
    else $error("response raised while the cache is idle");

endmodule

`default_nettype wire

/* sim/tbClock.sv */
`timescale 1ns/1ps
`default_nettype none

module tbClock (
  output logic clk_o,
  output logic rst_n_o
);

  initial begin
    clk_o = 1'b0;
    forever begin
      #5 clk_o = ~clk_o;
    end
  end

  // release just after the eighth rising edge
  initial begin
    rst_n_o = 1'b0;
    repeat (8) @(posedge clk_o);
    #1 rst_n_o = 1'b1;
  end

endmodule

`default_nettype wire

/* logic/dcacheTop.sv */
`timescale 1ns/1ps
`default_nettype none

module dcacheTop
  import dcachePkg::*;
(
  input  logic              clk,
  input  logic              rst_n,
  // load/store side
  input  logic              reqValid_i,
  input  logic              reqWrite_i,
  input  logic [ADDR_W-1:0] reqAddr_i,
  input  word_t             reqData_i,
  input  logic [MASK_W-1:0] reqMask_i,
  output logic              reqReady_o,
  output logic              respValid_o,
  output word_t             respData_o,
  // memory side
  output logic              rdReqValid_o,
  input  logic              rdReqReady_i,
  output logic [ADDR_W-1:0] rdReqAddr_o,
  input  logic              rdBeatValid_i,
  input  word_t             rdBeatData_i,
  input  logic              rdBeatLast_i,
  output logic              wrReqValid_o,
  input  logic              wrReqReady_i,
  output logic [ADDR_W-1:0] wrReqAddr_o,
  output line_t             wrLineData_o
);

  arrayIf arrLink ();
  refillIf fillLink ();

  dcacheCtrl uCtrl (
    .clk         (clk),
    .rst_n       (rst_n),
    .reqValid_i  (reqValid_i),
    .reqWrite_i  (reqWrite_i),
    .reqAddr_i   (reqAddr_i),
    .reqData_i   (reqData_i),
    .reqMask_i   (reqMask_i),
    .reqReady_o  (reqReady_o),
    .respValid_o (respValid_o),
    .arr         (arrLink.ctrl),
    .fill        (fillLink.ctrl)
  );

  dcacheArrays uArrays (
    .clk        (clk),
    .rst_n      (rst_n),
    .arr        (arrLink.arrays),
    .fill       (fillLink.arrays),
    .respData_o (respData_o)
  );

  busPort uBusPort (
    .clk           (clk),
    .rst_n         (rst_n),
    .fill          (fillLink.bus),
    .rdReqValid_o  (rdReqValid_o),
    .rdReqReady_i  (rdReqReady_i),
    .rdReqAddr_o   (rdReqAddr_o),
    .rdBeatValid_i (rdBeatValid_i),
    .rdBeatData_i  (rdBeatData_i),
    .rdBeatLast_i  (rdBeatLast_i),
    .wrReqValid_o  (wrReqValid_o),
    .wrReqReady_i  (wrReqReady_i),
    .wrReqAddr_o   (wrReqAddr_o),
    .wrLineData_o  (wrLineData_o)
  );

endmodule

`default_nettype wire

/* logic/busPort.sv */
`timescale 1ns/1ps
`default_nettype none

module busPort
  import dcachePkg::*;
(
  input  logic              clk,
  input  logic              rst_n,
  refillIf.bus              fill,
  output logic              rdReqValid_o,
  input  logic              rdReqReady_i,
  output logic [ADDR_W-1:0] rdReqAddr_o,
  input  logic              rdBeatValid_i,
  input  word_t             rdBeatData_i,
  input  logic              rdBeatLast_i,
  output logic              wrReqValid_o,
  input  logic              wrReqReady_i,
  output logic [ADDR_W-1:0] wrReqAddr_o,
  output line_t             wrLineData_o
);

  logic [$clog2(BEATS)-1:0] beatCnt;
  logic rdBusy;
  logic fillDoneQ;

  index_t idxQ;
  tag_t fillTagQ;
  tag_t wbTagQ;
  line_t wbLineQ;
  line_t fillBuf;

  // victim snapshot and refill buffer
  always_ff @(posedge clk) begin
    if (fill.wbStart || fill.fillStart) begin
      idxQ <= fill.lineIndex;
    end
    if (fill.wbStart) begin
      wbTagQ <= fill.victimTag;
      wbLineQ <= fill.victimLine;
    end
    if (fill.fillStart) begin
      fillTagQ <= fill.fillTag;
    end
    if (rdBusy && rdBeatValid_i) begin
      fillBuf[beatCnt*XLEN +: XLEN] <= rdBeatData_i;
    end
  end

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      wrReqValid_o <= 1'b0;
      rdReqValid_o <= 1'b0;
      rdBusy <= 1'b0;
      beatCnt <= '0;
      fillDoneQ <= 1'b0;
    end else begin
      if (fill.wbStart) begin
        wrReqValid_o <= 1'b1;
      end else if (wrReqReady_i) begin
        wrReqValid_o <= 1'b0;
      end
      if (fill.fillStart) begin
        rdReqValid_o <= 1'b1;
      end else if (rdReqReady_i) begin
        rdReqValid_o <= 1'b0;
      end
      // beats are only taken after the read request is accepted
      if (rdReqValid_o && rdReqReady_i) begin
        rdBusy <= 1'b1;
        beatCnt <= '0;
      end else if (rdBusy && rdBeatValid_i) begin
        beatCnt <= beatCnt + 1'b1;
        if (rdBeatLast_i) begin
          rdBusy <= 1'b0;
        end
      end
      fillDoneQ <= rdBusy && rdBeatValid_i && rdBeatLast_i;
    end
  end

  // write-back completes on the accepting edge
  assign fill.wbDone = wrReqValid_o && wrReqReady_i;
  assign fill.fillDone = fillDoneQ;
  assign fill.fillLine = fillBuf;

  assign rdReqAddr_o = {fillTagQ, idxQ, {OFFSET_W{1'b0}}};
  assign wrReqAddr_o = {wbTagQ, idxQ, {OFFSET_W{1'b0}}};
  assign wrLineData_o = wbLineQ;

endmodule

`default_nettype wire

/* logic/dcacheArrays.sv */
`timescale 1ns/1ps
`default_nettype none

module dcacheArrays
  import dcachePkg::*;
(
  input  logic     clk,
  input  logic     rst_n,
  arrayIf.arrays   arr,
  refillIf.arrays  fill,
  output word_t    respData_o
);

  tag_t tagMem [WAYS][SETS];
  line_t dataMem [WAYS][SETS];
  logic [SETS-1:0] validQ [WAYS];
  logic [SETS-1:0] dirtyQ [WAYS];
  // round-robin replacement, one bit per set
  logic [SETS-1:0] victimQ;

  index_t rdIndex;
  tag_t rdTag;
  logic [$clog2(BEATS)-1:0] rdWord;

  logic [WAYS-1:0] wayHit;
  logic hitWay;
  logic victimWay;
  line_t mergedLine;

  // registered read address gives the one-cycle read latency
  always_ff @(posedge clk) begin
    if (arr.lookupEn) begin
      rdIndex <= arr.index;
      rdTag <= arr.tag;
      rdWord <= arr.wordSel;
    end
  end

  always_comb begin
    for (int w = 0; w < WAYS; w++) begin
      wayHit[w] = validQ[w][rdIndex] && (tagMem[w][rdIndex] == rdTag);
    end
  end

  assign arr.hit = |wayHit;
  assign hitWay = wayHit[1];
  assign victimWay = victimQ[rdIndex];

  assign arr.readWord = dataMem[hitWay][rdIndex][rdWord*XLEN +: XLEN];
  assign respData_o = arr.readWord;

  assign arr.victimDirty = validQ[victimWay][rdIndex] && dirtyQ[victimWay][rdIndex];
  assign fill.victimTag = tagMem[victimWay][rdIndex];
  assign fill.victimLine = dataMem[victimWay][rdIndex];

  // byte merge of store data into the hit line
  always_comb begin
    mergedLine = dataMem[hitWay][rdIndex];
    for (int b = 0; b < MASK_W; b++) begin
      if (arr.storeMask[b]) begin
        mergedLine[rdWord*XLEN + b*8 +: 8] = arr.storeData[b*8 +: 8];
      end
    end
  end

  always_ff @(posedge clk) begin
    if (arr.installEn) begin
      dataMem[victimWay][rdIndex] <= fill.fillLine;
      tagMem[victimWay][rdIndex] <= rdTag;
    end else if (arr.storeEn) begin
      dataMem[hitWay][rdIndex] <= mergedLine;
    end
  end

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      for (int w = 0; w < WAYS; w++) begin
        validQ[w] <= '0;
        dirtyQ[w] <= '0;
      end
      victimQ <= '0;
    end else if (arr.installEn) begin
      validQ[victimWay][rdIndex] <= 1'b1;
      dirtyQ[victimWay][rdIndex] <= 1'b0;
      victimQ[rdIndex] <= !victimWay;
    end else if (arr.storeEn) begin
      dirtyQ[hitWay][rdIndex] <= 1'b1;
    end
  end

endmodule

`default_nettype wire

/* logic/dcacheCtrl.sv */
`timescale 1ns/1ps
`default_nettype none

module dcacheCtrl
  import dcachePkg::*;
(
  input  logic              clk,
  input  logic              rst_n,
  input  logic              reqValid_i,
  input  logic              reqWrite_i,
  input  logic [ADDR_W-1:0] reqAddr_i,
  input  word_t             reqData_i,
  input  logic [MASK_W-1:0] reqMask_i,
  output logic              reqReady_o,
  output logic              respValid_o,
  arrayIf.ctrl              arr,
  refillIf.ctrl             fill
);

  cacheState_e state;
  cacheState_e stateNext;

  memOp_e opQ;
  logic [ADDR_W-1:0] addrQ;
  word_t dataQ;
  logic [MASK_W-1:0] maskQ;

  logic accept;
  logic [ADDR_W-1:0] lookAddr;

  assign reqReady_o = (state == IDLE);
  assign accept = reqReady_o && reqValid_i;

  // request latch, held for the whole miss sequence
  always_ff @(posedge clk) begin
    if (accept) begin
      opQ <= reqWrite_i ? OP_STORE : OP_LOAD;
      addrQ <= reqAddr_i;
      dataQ <= reqData_i;
      maskQ <= reqMask_i;
    end
  end

  // the first lookup starts from the incoming address
  assign lookAddr = (state == IDLE) ? reqAddr_i : addrQ;

  assign arr.lookupEn = accept || (state == INSTALL);
  assign arr.index = lookAddr[OFFSET_W +: INDEX_W];
  assign arr.tag = lookAddr[ADDR_W-1 -: TAG_W];
  assign arr.wordSel = lookAddr[$clog2(MASK_W) +: $clog2(BEATS)];
  assign arr.storeData = dataQ;
  assign arr.storeMask = maskQ;
  assign arr.storeEn = (state == LOOKUP) && arr.hit && (opQ == OP_STORE);
  assign arr.installEn = (state == INSTALL);

  assign respValid_o = (state == LOOKUP) && arr.hit;

  assign fill.lineIndex = addrQ[OFFSET_W +: INDEX_W];
  assign fill.fillTag = addrQ[ADDR_W-1 -: TAG_W];
  // victim must leave before the refill overwrites its way
  assign fill.wbStart = (state == LOOKUP) && !arr.hit && arr.victimDirty;
  assign fill.fillStart = (state == REFILLREQ);

  always_comb begin
    stateNext = state;
    case (state)
      IDLE: begin
        if (accept) begin
          stateNext = LOOKUP;
        end
      end
      LOOKUP: begin
        if (arr.hit) begin
          stateNext = IDLE;
        end else if (arr.victimDirty) begin
          stateNext = WRITEBACK;
        end else begin
          stateNext = REFILLREQ;
        end
      end
      WRITEBACK: begin
        if (fill.wbDone) begin
          stateNext = REFILLREQ;
        end
      end
      REFILLREQ: begin
        stateNext = REFILL;
      end
      REFILL: begin
        if (fill.fillDone) begin
          stateNext = INSTALL;
        end
      end
      INSTALL: begin
        // relookup, which now hits
        stateNext = LOOKUP;
      end
      default: begin
        stateNext = IDLE;
      end
    endcase
  end

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      state <= IDLE;
    end else begin
      state <= stateNext;
    end
  end

endmodule

`default_nettype wire

/* logic/refillIf.sv */
`timescale 1ns/1ps
`default_nettype none

interface refillIf
  import dcachePkg::*;
();

  logic wbStart;
  logic fillStart;
  index_t lineIndex;
  tag_t fillTag;
  tag_t victimTag;
  line_t victimLine;
  logic wbDone;
  logic fillDone;
  line_t fillLine;

  modport ctrl (
    output wbStart, fillStart, lineIndex, fillTag,
    input wbDone, fillDone
  );

  modport arrays (
    input fillLine,
    output victimTag, victimLine
  );

  modport bus (
    input wbStart, fillStart, lineIndex, fillTag, victimTag, victimLine,
    output wbDone, fillDone, fillLine
  );

endinterface

`default_nettype wire

/* logic/arrayIf.sv */
`timescale 1ns/1ps
`default_nettype none

interface arrayIf
  import dcachePkg::*;
();

  // lookup and store commands from the controller
  logic lookupEn;
  index_t index;
  tag_t tag;
  logic [$clog2(BEATS)-1:0] wordSel;
  logic storeEn;
  word_t storeData;
  logic [MASK_W-1:0] storeMask;
  logic installEn;

  // results, one cycle after lookupEn
  logic hit;
  word_t readWord;
  logic victimDirty;

  modport ctrl (
    output lookupEn, index, tag, wordSel, storeEn, storeData, storeMask, installEn,
    input hit, victimDirty
  );

  modport arrays (
    input lookupEn, index, tag, wordSel, storeEn, storeData, storeMask, installEn,
    output hit, readWord, victimDirty
  );

endinterface

`default_nettype wire

/* logic/dcachePkg.sv */
`default_nettype none

package dcachePkg;

  // request and data widths
  localparam int ADDR_W = 32;
  localparam int XLEN = 64;
  localparam int MASK_W = 8;

  // cache geometry
  localparam int LINE_W = 256;
  localparam int BEATS = 4;
  localparam int SETS = 64;
  localparam int INDEX_W = 6;
  localparam int OFFSET_W = 5;
  localparam int TAG_W = 21;
  localparam int WAYS = 2;

  typedef logic [XLEN-1:0] word_t;
  typedef logic [LINE_W-1:0] line_t;
  typedef logic [TAG_W-1:0] tag_t;
  typedef logic [INDEX_W-1:0] index_t;

  typedef enum logic {
    OP_LOAD,
    OP_STORE
  } memOp_e;

  typedef enum logic [2:0] {
    IDLE,
    LOOKUP,
    WRITEBACK,
    REFILLREQ,
    REFILL,
    INSTALL
  } cacheState_e;

endpackage

`default_nettype wire
